// ==== rename_macros.svh ====
`ifndef RN_MACROS_SVH
`define RN_MACROS_SVH

// logical and physical register file sizes
`define RN_NUM_LREG 32
`define RN_NUM_PREG 64

// field widths
`define RN_LREG_W 5
`define RN_PREG_W 6
`define RN_PC_W 32

// dispatch buffer slots granted after reset
`define RN_CREDITS 8

`endif

// ==== rename_pkg.sv ====
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // register numbers
    typedef logic [`RN_LREG_W-1:0] lreg_t;
    typedef logic [`RN_PREG_W-1:0] preg_t;

    // alu operation, passed through rename untouched
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== hazardchecker.sv ====
`default_nettype none

module hazardchecker (
    input  wire rename_pkg::lreg_t instr0_lrs1,
    input  wire rename_pkg::lreg_t instr0_lrs2,
    input  wire rename_pkg::lreg_t instr0_lrd,
    input  wire rename_pkg::lreg_t instr1_lrs1,
    input  wire rename_pkg::lreg_t instr1_lrs2,
    input  wire rename_pkg::lreg_t instr1_lrd,
    input  wire                    instr0_lrs1_valid,
    input  wire                    instr0_lrs2_valid,
    input  wire                    instr0_lrd_valid,
    input  wire                    instr1_lrs1_valid,
    input  wire                    instr1_lrs2_valid,
    input  wire                    instr1_lrd_valid,
    output logic                   raw_hazard_rs1,
    output logic                   raw_hazard_rs2,
    output logic                   waw_hazard
);

    // instr0 sources read the table before any write of the pair lands
    // so only instr1 sources can depend on the other instruction

    // instr1 reads what instr0 writes in the same pair
    assign raw_hazard_rs1 = instr1_lrs1_valid & instr0_lrd_valid & (instr1_lrs1 == instr0_lrd);
    assign raw_hazard_rs2 = instr1_lrs2_valid & instr0_lrd_valid & (instr1_lrs2 == instr0_lrd);

    // both write the same logical register
    assign waw_hazard = instr0_lrd_valid & instr1_lrd_valid & (instr0_lrd == instr1_lrd);

endmodule

`default_nettype wire

// ==== spec_rat.sv ====
`default_nettype none

`include "rename_macros.svh"

module spec_rat (
    input  wire                    clock,
    input  wire                    rst_n,
    // lookups for instr0 lrs1, lrs2, lrd then instr1 lrs1, lrs2, lrd
    input  wire rename_pkg::lreg_t rd_lreg0,
    input  wire rename_pkg::lreg_t rd_lreg1,
    input  wire rename_pkg::lreg_t rd_lreg2,
    input  wire rename_pkg::lreg_t rd_lreg3,
    input  wire rename_pkg::lreg_t rd_lreg4,
    input  wire rename_pkg::lreg_t rd_lreg5,
    output rename_pkg::preg_t      rd_preg0,
    output rename_pkg::preg_t      rd_preg1,
    output rename_pkg::preg_t      rd_preg2,
    output rename_pkg::preg_t      rd_preg3,
    output rename_pkg::preg_t      rd_preg4,
    output rename_pkg::preg_t      rd_preg5,
    // new mappings
    input  wire                    wr_en0,
    input  wire rename_pkg::lreg_t wr_lreg0,
    input  wire rename_pkg::preg_t wr_preg0,
    input  wire                    wr_en1,
    input  wire rename_pkg::lreg_t wr_lreg1,
    input  wire rename_pkg::preg_t wr_preg1
);

    import rename_pkg::*;

    preg_t map_table [`RN_NUM_LREG];

    // reads see the table as it stood before this edge
    assign rd_preg0 = map_table[rd_lreg0];
    assign rd_preg1 = map_table[rd_lreg1];
    assign rd_preg2 = map_table[rd_lreg2];
    assign rd_preg3 = map_table[rd_lreg3];
    assign rd_preg4 = map_table[rd_lreg4];
    assign rd_preg5 = map_table[rd_lreg5];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // identity map, x_i lives in p_i
            for (int i = 0; i < `RN_NUM_LREG; i++) begin
                map_table[i] <= preg_t'(i);
            end
        end else begin
            if (wr_en0) begin
                map_table[wr_lreg0] <= wr_preg0;
            end
            // port 1 is the younger instruction and wins on a clash
            if (wr_en1) begin
                map_table[wr_lreg1] <= wr_preg1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== free_list.sv ====
`default_nettype none

`include "rename_macros.svh"

module free_list (
    input  wire                    clock,
    input  wire                    rst_n,
    // allocation for instr0 and instr1 destinations
    input  wire                    alloc0,
    input  wire                    alloc1,
    output rename_pkg::preg_t      alloc_prd0,
    output rename_pkg::preg_t      alloc_prd1,
    output logic [6:0]             free_count,
    // one register back from commit per cycle
    input  wire                    release_valid,
    input  wire rename_pkg::preg_t release_prd
);

    import rename_pkg::*;

    localparam int DEPTH = `RN_NUM_PREG - `RN_NUM_LREG;
    // depth is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);

    preg_t            fifo [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] head_plus1;
    logic [PTR_W-1:0] tail;
    logic [1:0]       n_pop;

    assign head_plus1 = head + 1'b1;

    assign alloc_prd0 = fifo[head];
    // a lone alloc1 takes the oldest entry
    assign alloc_prd1 = alloc0 ? fifo[head_plus1] : fifo[head];

    assign n_pop = {1'b0, alloc0} + {1'b0, alloc1};

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            free_count <= 7'(DEPTH);
            // p32 .. p63 free in order, the rest are mapped by the RAT
            for (int i = 0; i < DEPTH; i++) begin
                fifo[i] <= preg_t'(`RN_NUM_LREG + i);
            end
        end else begin
            head <= head + PTR_W'(n_pop);
            if (release_valid) begin
                fifo[tail] <= release_prd;
                tail       <= tail + 1'b1;
            end
            // release shows up in the count one cycle later
            free_count <= free_count - 7'(n_pop) + 7'(release_valid);
        end
    end

endmodule

`default_nettype wire

// ==== rename.sv ====
`default_nettype none

`include "rename_macros.svh"

module rename (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       flush,
    // decoder side
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire                       in_instr0_valid, in_instr0_src1_is_reg,
    input  wire                       in_instr0_src2_is_reg, in_instr0_need_to_wb,
    input  wire rename_pkg::lreg_t    in_instr0_lrs1, in_instr0_lrs2, in_instr0_lrd,
    input  wire rename_pkg::alu_op_e  in_instr0_alu_op,
    input  wire [`RN_PC_W-1:0]        in_instr0_pc,
    input  wire                       in_instr1_valid, in_instr1_src1_is_reg,
    input  wire                       in_instr1_src2_is_reg, in_instr1_need_to_wb,
    input  wire rename_pkg::lreg_t    in_instr1_lrs1, in_instr1_lrs2, in_instr1_lrd,
    input  wire rename_pkg::alu_op_e  in_instr1_alu_op,
    input  wire [`RN_PC_W-1:0]        in_instr1_pc,
    // dispatch side
    output logic                      out_instr0_valid,
    output rename_pkg::preg_t         out_instr0_prs1, out_instr0_prs2,
    output rename_pkg::preg_t         out_instr0_prd, out_instr0_old_prd,
    output rename_pkg::lreg_t         out_instr0_lrd,
    output rename_pkg::alu_op_e       out_instr0_alu_op,
    output logic [`RN_PC_W-1:0]       out_instr0_pc,
    output logic                      out_instr1_valid,
    output rename_pkg::preg_t         out_instr1_prs1, out_instr1_prs2,
    output rename_pkg::preg_t         out_instr1_prd, out_instr1_old_prd,
    output rename_pkg::lreg_t         out_instr1_lrd,
    output rename_pkg::alu_op_e       out_instr1_alu_op,
    output logic [`RN_PC_W-1:0]       out_instr1_pc,
    input  wire                       credit_return,
    // spec_rat
    output rename_pkg::lreg_t         rd_lreg0, rd_lreg1, rd_lreg2,
    output rename_pkg::lreg_t         rd_lreg3, rd_lreg4, rd_lreg5,
    input  wire rename_pkg::preg_t    rd_preg0, rd_preg1, rd_preg2,
    input  wire rename_pkg::preg_t    rd_preg3, rd_preg4, rd_preg5,
    output logic                      wr_en0, wr_en1,
    output rename_pkg::lreg_t         wr_lreg0, wr_lreg1,
    output rename_pkg::preg_t         wr_preg0, wr_preg1,
    // free_list
    output logic                      alloc0, alloc1,
    input  wire rename_pkg::preg_t    alloc_prd0, alloc_prd1,
    input  wire [6:0]                 free_count,
    // hazardchecker
    output logic                      instr0_lrs1_valid, instr0_lrs2_valid, instr0_lrd_valid,
    output logic                      instr1_lrs1_valid, instr1_lrs2_valid, instr1_lrd_valid,
    input  wire                       raw_hazard_rs1, raw_hazard_rs2, waw_hazard
);

    import rename_pkg::*;

    localparam int CRD_W = $clog2(`RN_CREDITS + 1);
    localparam int SUM_W = CRD_W + 1;

    logic [CRD_W-1:0] credits;
    logic [SUM_W-1:0] credits_sum;
    logic [1:0]       n_sent;
    logic             accept;
    logic             send0;
    logic             send1;
    preg_t            instr1_prs1;
    preg_t            instr1_prs2;

    assign instr0_lrs1_valid = in_instr0_valid & in_instr0_src1_is_reg;
    assign instr0_lrs2_valid = in_instr0_valid & in_instr0_src2_is_reg;
    assign instr0_lrd_valid  = in_instr0_valid & in_instr0_need_to_wb;
    assign instr1_lrs1_valid = in_instr1_valid & in_instr1_src1_is_reg;
    assign instr1_lrs2_valid = in_instr1_valid & in_instr1_src2_is_reg;
    assign instr1_lrd_valid  = in_instr1_valid & in_instr1_need_to_wb;

    // room for a full pair downstream and in the free list
    assign in_ready = !flush && (credits >= CRD_W'(2)) && (free_count >= 7'd2);
    assign accept   = in_valid & in_ready;
    assign send0    = accept & in_instr0_valid;
    assign send1    = accept & in_instr1_valid;

    assign rd_lreg0 = in_instr0_lrs1;
    assign rd_lreg1 = in_instr0_lrs2;
    assign rd_lreg2 = in_instr0_lrd;
    assign rd_lreg3 = in_instr1_lrs1;
    assign rd_lreg4 = in_instr1_lrs2;
    assign rd_lreg5 = in_instr1_lrd;

    assign alloc0 = accept & instr0_lrd_valid;
    assign alloc1 = accept & instr1_lrd_valid;

    // instr1 picks up instr0's new register instead of the stale mapping
    assign instr1_prs1 = raw_hazard_rs1 ? alloc_prd0 : rd_preg3;
    assign instr1_prs2 = raw_hazard_rs2 ? alloc_prd0 : rd_preg4;

    // on waw only instr1's mapping is kept
    assign wr_en0   = alloc0 & ~waw_hazard;
    assign wr_lreg0 = in_instr0_lrd;
    assign wr_preg0 = alloc_prd0;
    assign wr_en1   = alloc1;
    assign wr_lreg1 = in_instr1_lrd;
    assign wr_preg1 = alloc_prd1;

    // a send and a return in the same cycle both count
    assign n_sent      = {1'b0, send0} + {1'b0, send1};
    assign credits_sum = {1'b0, credits} + SUM_W'(credit_return) - SUM_W'(n_sent);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRD_W'(`RN_CREDITS);
        end else if (credits_sum > SUM_W'(`RN_CREDITS)) begin
            credits <= CRD_W'(`RN_CREDITS);
        end else begin
            credits <= credits_sum[CRD_W-1:0];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_instr0_valid <= 1'b0;
            out_instr1_valid <= 1'b0;
        end else begin
            out_instr0_valid <= send0;
            out_instr1_valid <= send1;
        end
    end

    // renamed pair, held until the next acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            out_instr0_prs1    <= rd_preg0;
            out_instr0_prs2    <= rd_preg1;
            out_instr0_prd     <= alloc_prd0;
            out_instr0_old_prd <= rd_preg2;
            out_instr0_lrd     <= in_instr0_lrd;
            out_instr0_alu_op  <= in_instr0_alu_op;
            out_instr0_pc      <= in_instr0_pc;
            out_instr1_prs1    <= instr1_prs1;
            out_instr1_prs2    <= instr1_prs2;
            out_instr1_prd     <= alloc_prd1;
            out_instr1_old_prd <= rd_preg5;
            out_instr1_lrd     <= in_instr1_lrd;
            out_instr1_alu_op  <= in_instr1_alu_op;
            out_instr1_pc      <= in_instr1_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rename_top.sv ====
`default_nettype none

`include "rename_macros.svh"

module rename_top (
    input  wire                       clock,
    input  wire                       rst_n,
    input  wire                       flush,
    // decoder side
    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire                       in_instr0_valid, in_instr0_src1_is_reg,
    input  wire                       in_instr0_src2_is_reg, in_instr0_need_to_wb,
    input  wire rename_pkg::lreg_t    in_instr0_lrs1, in_instr0_lrs2, in_instr0_lrd,
    input  wire rename_pkg::alu_op_e  in_instr0_alu_op,
    input  wire [`RN_PC_W-1:0]        in_instr0_pc,
    input  wire                       in_instr1_valid, in_instr1_src1_is_reg,
    input  wire                       in_instr1_src2_is_reg, in_instr1_need_to_wb,
    input  wire rename_pkg::lreg_t    in_instr1_lrs1, in_instr1_lrs2, in_instr1_lrd,
    input  wire rename_pkg::alu_op_e  in_instr1_alu_op,
    input  wire [`RN_PC_W-1:0]        in_instr1_pc,
    // dispatch side
    output logic                      out_instr0_valid,
    output rename_pkg::preg_t         out_instr0_prs1, out_instr0_prs2,
    output rename_pkg::preg_t         out_instr0_prd, out_instr0_old_prd,
    output rename_pkg::lreg_t         out_instr0_lrd,
    output rename_pkg::alu_op_e       out_instr0_alu_op,
    output logic [`RN_PC_W-1:0]       out_instr0_pc,
    output logic                      out_instr1_valid,
    output rename_pkg::preg_t         out_instr1_prs1, out_instr1_prs2,
    output rename_pkg::preg_t         out_instr1_prd, out_instr1_old_prd,
    output rename_pkg::lreg_t         out_instr1_lrd,
    output rename_pkg::alu_op_e       out_instr1_alu_op,
    output logic [`RN_PC_W-1:0]       out_instr1_pc,
    input  wire                       credit_return,
    // commit side
    input  wire                       commit_valid,
    input  wire rename_pkg::preg_t    commit_old_prd
);

    import rename_pkg::*;

    // spec_rat ports
    lreg_t      rd_lreg0, rd_lreg1, rd_lreg2;
    lreg_t      rd_lreg3, rd_lreg4, rd_lreg5;
    preg_t      rd_preg0, rd_preg1, rd_preg2;
    preg_t      rd_preg3, rd_preg4, rd_preg5;
    logic       wr_en0, wr_en1;
    lreg_t      wr_lreg0, wr_lreg1;
    preg_t      wr_preg0, wr_preg1;

    // free_list ports
    logic       alloc0, alloc1;
    preg_t      alloc_prd0, alloc_prd1;
    logic [6:0] free_count;

    // hazardchecker ports
    logic       instr0_lrs1_valid, instr0_lrs2_valid, instr0_lrd_valid;
    logic       instr1_lrs1_valid, instr1_lrs2_valid, instr1_lrd_valid;
    logic       raw_hazard_rs1, raw_hazard_rs2, waw_hazard;

    rename u_rename (.*);

    hazardchecker u_hazardchecker (
        .instr0_lrs1 (in_instr0_lrs1),
        .instr0_lrs2 (in_instr0_lrs2),
        .instr0_lrd  (in_instr0_lrd),
        .instr1_lrs1 (in_instr1_lrs1),
        .instr1_lrs2 (in_instr1_lrs2),
        .instr1_lrd  (in_instr1_lrd),
        .*
    );

    spec_rat u_spec_rat (.*);

    // commit hands back the register the retired instruction replaced
    free_list u_free_list (
        .release_valid (commit_valid),
        .release_prd   (commit_old_prd),
        .*
    );

endmodule

`default_nettype wire

// ==== tb_rename_top.sv ====
`default_nettype none

`include "rename_macros.svh"

module tb_rename_top;

    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;

    localparam int MAX_LINES  = 64;
    localparam int NUM_FIELDS = 17;

    logic                clock;
    logic                rst_n;
    logic                flush;
    logic                in_valid;
    logic                in_ready;
    logic                in_instr0_valid, in_instr0_src1_is_reg;
    logic                in_instr0_src2_is_reg, in_instr0_need_to_wb;
    lreg_t               in_instr0_lrs1, in_instr0_lrs2, in_instr0_lrd;
    alu_op_e             in_instr0_alu_op;
    logic [`RN_PC_W-1:0] in_instr0_pc;
    logic                in_instr1_valid, in_instr1_src1_is_reg;
    logic                in_instr1_src2_is_reg, in_instr1_need_to_wb;
    lreg_t               in_instr1_lrs1, in_instr1_lrs2, in_instr1_lrd;
    alu_op_e             in_instr1_alu_op;
    logic [`RN_PC_W-1:0] in_instr1_pc;
    logic                out_instr0_valid;
    preg_t               out_instr0_prs1, out_instr0_prs2, out_instr0_prd, out_instr0_old_prd;
    lreg_t               out_instr0_lrd;
    alu_op_e             out_instr0_alu_op;
    logic [`RN_PC_W-1:0] out_instr0_pc;
    logic                out_instr1_valid;
    preg_t               out_instr1_prs1, out_instr1_prs2, out_instr1_prd, out_instr1_old_prd;
    lreg_t               out_instr1_lrd;
    alu_op_e             out_instr1_alu_op;
    logic [`RN_PC_W-1:0] out_instr1_pc;
    logic                credit_return;
    logic                commit_valid;
    preg_t               commit_old_prd;

    // pattern table, one row per stimulus line
    logic [31:0] pat [MAX_LINES][NUM_FIELDS];
    int          num_lines;

    // reference model
    preg_t       model_rat [`RN_NUM_LREG];
    preg_t       free_q [$];
    int          model_credits;
    int          outstanding;
    int          gap;
    logic [31:0] lfsr;
    logic [31:0] exp_val [2][7];
    bit          exp_chk [2][7];
    bit          exp_valid [2];
    string       field_name [7] = '{"prs1", "prs2", "prd", "old_prd", "lrd", "alu_op", "pc"};

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit  = 0;

    rename_top u_rename_top (.*);

    initial clock = 1'b0;
    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the rename stage stopped taking pairs", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'hA300_0000;
        end
        return next;
    endfunction

    // two fresh bits give a gap of 0 to 3 cycles
    task automatic draw_gap(output int g);
        g = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            g    = (g << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic read_patterns(output bit ok);
        int          fd;
        int          n;
        string       text;
        logic [31:0] f [NUM_FIELDS];
        num_lines = 0;
        fd = $fopen("rename_patterns.txt", "r");
        ok = (fd != 0);
        if (!ok) begin
            $display("could not open rename_patterns.txt");
        end
        while (ok && !$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            // comment and blank lines carry no stimulus
            if (text.len() > 1 && text.getc(0) != "#") begin
                n = $sscanf(text, "%d %d %b %d %d %d %d %h %b %d %d %d %d %h %d %d %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (n != NUM_FIELDS || num_lines == MAX_LINES) begin
                    $display("pattern line could not be used: %s", text);
                    ok = 1'b0;
                end else begin
                    pat[num_lines] = f;
                    num_lines++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        flush         = 1'b0;
        in_valid      = 1'b0;
        credit_return = 1'b0;
        commit_valid  = 1'b0;
        commit_old_prd = '0;
        {in_instr0_valid, in_instr0_src1_is_reg, in_instr0_src2_is_reg} = '0;
        {in_instr1_valid, in_instr1_src1_is_reg, in_instr1_src2_is_reg} = '0;
        {in_instr0_need_to_wb, in_instr1_need_to_wb} = '0;
        {in_instr0_lrs1, in_instr0_lrs2, in_instr0_lrd} = '0;
        {in_instr1_lrs1, in_instr1_lrs2, in_instr1_lrd} = '0;
        in_instr0_alu_op = ADD;
        in_instr1_alu_op = ADD;
        in_instr0_pc     = '0;
        in_instr1_pc     = '0;
    endtask

    task automatic model_reset();
        for (int i = 0; i < `RN_NUM_LREG; i++) begin
            model_rat[i] = preg_t'(i);
        end
        free_q.delete();
        for (int i = `RN_NUM_LREG; i < `RN_NUM_PREG; i++) begin
            free_q.push_back(preg_t'(i));
        end
        model_credits = `RN_CREDITS;
        outstanding   = 0;
        exp_valid     = '{1'b0, 1'b0};
    endtask

    // out ports show the pair accepted at the last rising edge
    task automatic check_outputs();
        logic [31:0] got [2][7];
        got[0] = '{out_instr0_prs1, out_instr0_prs2, out_instr0_prd, out_instr0_old_prd,
                   out_instr0_lrd, out_instr0_alu_op, out_instr0_pc};
        got[1] = '{out_instr1_prs1, out_instr1_prs2, out_instr1_prd, out_instr1_old_prd,
                   out_instr1_lrd, out_instr1_alu_op, out_instr1_pc};
        check_value("out_instr0_valid", exp_valid[0], out_instr0_valid);
        check_value("out_instr1_valid", exp_valid[1], out_instr1_valid);
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 7; j++) begin
                if (exp_valid[k] && exp_chk[k][j]) begin
                    check_value($sformatf("out_instr%0d_%s", k, field_name[j]),
                                exp_val[k][j], got[k][j]);
                end
            end
        end
    endtask

    task automatic run_cycle(input int ln, input bit first_cycle, input bit hold_returns,
                             output bit accepted);
        logic [31:0] f [NUM_FIELDS];
        bit          ready;
        bit          ret;
        bit          v [2];
        bit          src1 [2];
        bit          src2 [2];
        bit          wb [2];
        lreg_t       rs1 [2];
        lreg_t       rs2 [2];
        lreg_t       rd [2];
        int          base;
        int          sent;
        f = pat[ln];
        @(negedge clock);
        check_outputs();
        // dispatch hands a slot back after a random gap
        ret = 1'b0;
        if (!hold_returns && outstanding > 0) begin
            if (gap == 0) begin
                ret = 1'b1;
                draw_gap(gap);
            end else begin
                gap--;
            end
        end
        in_valid = f[0][0];
        flush    = f[1][0];
        {in_instr0_valid, in_instr0_src1_is_reg, in_instr0_src2_is_reg,
         in_instr0_need_to_wb} = f[2][3:0];
        in_instr0_lrs1   = lreg_t'(f[3]);
        in_instr0_lrs2   = lreg_t'(f[4]);
        in_instr0_lrd    = lreg_t'(f[5]);
        in_instr0_alu_op = alu_op_e'(f[6][2:0]);
        in_instr0_pc     = f[7];
        {in_instr1_valid, in_instr1_src1_is_reg, in_instr1_src2_is_reg,
         in_instr1_need_to_wb} = f[8][3:0];
        in_instr1_lrs1   = lreg_t'(f[9]);
        in_instr1_lrs2   = lreg_t'(f[10]);
        in_instr1_lrd    = lreg_t'(f[11]);
        in_instr1_alu_op = alu_op_e'(f[12][2:0]);
        in_instr1_pc     = f[13];
        // a held line commits only once
        commit_valid   = first_cycle & f[14][0];
        commit_old_prd = preg_t'(f[15]);
        credit_return  = ret;
        #1;
        ready = !flush && model_credits >= 2 && free_q.size() >= 2;
        check_value("in_ready", ready, in_ready);
        accepted = in_valid && ready;
        sent = 0;
        for (int k = 0; k < 2; k++) begin
            base         = 2 + 6 * k;
            v[k]         = f[base][3];
            src1[k]      = f[base][3] & f[base][2];
            src2[k]      = f[base][3] & f[base][1];
            wb[k]        = f[base][3] & f[base][0];
            rs1[k]       = lreg_t'(f[base + 1]);
            rs2[k]       = lreg_t'(f[base + 2]);
            rd[k]        = lreg_t'(f[base + 3]);
            exp_valid[k] = accepted & v[k];
        end
        if (accepted) begin
            // every lookup sees the table before this pair's writes
            for (int k = 0; k < 2; k++) begin
                base = 2 + 6 * k;
                exp_val[k] = '{model_rat[rs1[k]], model_rat[rs2[k]], 0, model_rat[rd[k]],
                               rd[k], f[base + 4][2:0], f[base + 5]};
                exp_chk[k] = '{src1[k], src2[k], wb[k], 1'b1, 1'b1, 1'b1, 1'b1};
                if (wb[k]) begin
                    exp_val[k][2] = free_q.pop_front();
                end
                if (v[k]) begin
                    sent++;
                end
            end
            if (src1[1] && wb[0] && rs1[1] == rd[0]) begin
                exp_val[1][0] = exp_val[0][2];
            end
            if (src2[1] && wb[0] && rs2[1] == rd[0]) begin
                exp_val[1][1] = exp_val[0][2];
            end
            // the younger write wins when both target one register
            if (wb[0] && !(wb[1] && rd[0] == rd[1])) begin
                model_rat[rd[0]] = preg_t'(exp_val[0][2]);
            end
            if (wb[1]) begin
                model_rat[rd[1]] = preg_t'(exp_val[1][2]);
            end
        end
        outstanding   = outstanding + sent - int'(ret);
        model_credits = model_credits - sent + int'(ret);
        if (model_credits > `RN_CREDITS) begin
            model_credits = `RN_CREDITS;
        end
        if (commit_valid) begin
            free_q.push_back(commit_old_prd);
        end
    endtask

    initial begin
        bit ok;
        bit acc;
        int held;
        lfsr  = 32'h66aac536;
        rst_n = 1'b0;
        drive_idle();
        read_patterns(ok);
        if (!ok) begin
            $display("stimulus could not be read, no test was run");
            $display("=== FAIL ===");
            $finish;
        end else begin
            limit = 4 * num_lines + 100;
            model_reset();
            draw_gap(gap);
            repeat (3) @(posedge clock);
            @(negedge clock);
            rst_n = 1'b1;
            for (int ln = 0; ln < num_lines; ln++) begin
                held = 0;
                // an offered pair stays on the inputs until it is taken
                do begin
                    run_cycle(ln, held == 0, held < int'(pat[ln][16]), acc);
                    held++;
                end while (pat[ln][0][0] && !pat[ln][1][0] && !acc);
            end
            @(negedge clock);
            check_outputs();
            drive_idle();
            $display("errors: %0d in %0d checks", errors, checks);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rename_patterns.txt ====
# iv fl flags0 lrs1 lrs2 lrd op pc0 flags1 lrs1 lrs2 lrd op pc1 commit_valid commit_prd hold
# flags are valid src1_is_reg src2_is_reg need_to_wb, hold blocks credit returns that many cycles
1 0 1111 1 2 3 0 00001000 1111 4 5 6 1 00001004 0 0 1
1 0 1111 3 7 8 2 00001008 1111 8 9 10 3 0000100c 0 0 1
1 0 1111 11 12 13 4 00001010 1111 14 13 13 5 00001014 0 0 1
1 0 1111 13 13 15 6 00001018 1111 16 17 18 7 0000101c 0 0 1
1 0 1111 19 20 21 0 00001020 1111 22 23 24 1 00001024 0 0 6
1 1 1111 1 2 25 2 00001028 1111 3 4 26 3 0000102c 0 0 0
1 0 1111 25 26 27 2 00001028 1111 27 29 30 3 0000102c 0 0 0
1 0 1111 30 31 2 4 00001030 1111 2 6 7 5 00001034 1 3 0
1 0 1111 5 8 9 6 00001038 1111 10 11 12 7 0000103c 1 6 0
1 0 1111 12 14 16 0 00001040 1111 16 17 19 1 00001044 1 8 0
0 0 0000 0 0 0 0 00000000 0000 0 0 0 0 00000000 1 10 0
1 0 1111 20 21 22 2 00001048 1111 23 24 25 3 0000104c 1 15 0
1 0 1111 26 27 28 4 00001050 1111 28 29 28 5 00001054 1 18 0
1 0 1111 1 4 11 6 00001058 1111 14 18 20 7 0000105c 0 0 0
1 0 1101 3 0 5 0 00001060 1111 5 6 8 1 00001064 0 0 0
1 0 1111 7 9 13 2 00001068 1111 13 15 17 3 0000106c 0 0 0
1 0 1111 19 21 23 4 00001070 1111 24 25 26 5 00001074 0 0 0
1 0 1111 27 28 29 6 00001078 1111 30 31 1 7 0000107c 0 0 0
1 0 1111 2 3 4 0 00001080 1111 4 5 6 1 00001084 0 0 0
1 0 1111 7 8 9 2 00001088 1111 10 11 12 3 0000108c 0 0 0
1 0 1111 13 14 15 4 00001090 1111 16 17 18 5 00001094 0 0 0

// ==== compile.f ====
+incdir+.
rename_pkg.sv
hazardchecker.sv
spec_rat.sv
free_list.sv
rename.sv
rename_top.sv
tb_rename_top.sv

// ==== Bender.yml ====
package:
  name: rename_stage

# rename_top is the design top, tb_rename_top drives it in simulation
sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - hazardchecker.sv
      - spec_rat.sv
      - free_list.sv
      - rename.sv
      - rename_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rename_top.sv
